// File: Bender.yml
package:
  name: ic_mem

sources:
  - ic_pkg.sv
  - ic_sram.sv
  - ic_tag_array.sv
  - ic_data_array.sv
  - ic_mem.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_ic_mem.sv

// File: filelist.f
+incdir+.
ic_pkg.sv
ic_sram.sv
ic_tag_array.sv
ic_data_array.sv
ic_mem.sv
tb_ic_mem.sv

// File: ic_data_array.sv
`timescale 1ns/1ps
// Data ways, each row split into four 34-bit subbanks of 16 bytes per row
// A fill beat writes two subbanks of the enabled ways, address bit 3 picks the half
// Output is the OR of the selected ways, so a multi-hot select merges rows
// Subbank parity bits pass through untouched
module ic_data_array
   import ic_pkg::*;
#(
   parameter int ICACHE_TAG_HIGH = 12
) (
   input  logic                       clk,
   input  logic                       rst_n,
   input  logic [ICACHE_TAG_HIGH-1:3] ic_rw_addr,
   input  way_vec_t                   ic_wr_en,
   input  logic                       ic_rd_en,
   input  fill_data_t                 ic_wr_data,
   input  logic [ICACHE_TAG_HIGH-1:2] ic_debug_addr,
   input  logic                       ic_debug_rd_en,
   input  logic                       ic_debug_wr_en,
   input  logic                       ic_debug_tag_array,
   input  way_vec_t                   ic_debug_way,
   input  subbank_t                   ic_debug_wr_data,
   input  way_vec_t                   ic_rd_hit,
   output line_data_t                 ic_rd_data
);

   localparam int ROW_DEPTH = 2 ** (ICACHE_TAG_HIGH - 4);

   way_vec_t                   dbg_rd_way;
   way_vec_t                   dbg_wr_way;
   way_vec_t                   dbg_rd_way_ff;
   way_vec_t                   way_re;
   way_vec_t                   rd_sel;
   logic                       dbg_data_wr;
   logic                       dbg_rd_ff;
   logic [ICACHE_TAG_HIGH-1:4] row_idx;
   subbank_t                   sb_wr_data [NUM_SUBBANKS];
   subbank_t                   sb_q       [NUM_WAYS][NUM_SUBBANKS];

   //////////////////////////////////////////////////
   // Write steering
   //////////////////////////////////////////////////

   assign dbg_data_wr = ic_debug_wr_en & ~ic_debug_tag_array;
   assign dbg_rd_way  = {NUM_WAYS{ic_debug_rd_en & ~ic_debug_tag_array}} & ic_debug_way;
   assign dbg_wr_way  = {NUM_WAYS{dbg_data_wr}} & ic_debug_way;
   assign way_re      = {NUM_WAYS{ic_rd_en}} | dbg_rd_way;

   assign row_idx = (ic_debug_rd_en | ic_debug_wr_en) ? ic_debug_addr[ICACHE_TAG_HIGH-1:4]
                                                      : ic_rw_addr[ICACHE_TAG_HIGH-1:4];

   // Even subbanks take the low half of a fill beat, odd ones the high half
   for (genvar s = 0; s < NUM_SUBBANKS; s++) begin : g_sb_wdata
      assign sb_wr_data[s] = (dbg_data_wr && (ic_debug_addr[3:2] == 2'(s)))
                             ? ic_debug_wr_data
                             : ic_wr_data[(s % 2) * SUBBANK_W +: SUBBANK_W];
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_rd_ff     <= 1'b0;
         dbg_rd_way_ff <= '0;
      end else begin
         dbg_rd_ff     <= ic_debug_rd_en;        // Any debug read takes the output
         dbg_rd_way_ff <= dbg_rd_way;
      end
   end

   //////////////////////////////////////////////////
   // Way by subbank RAMs
   //////////////////////////////////////////////////

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      for (genvar s = 0; s < NUM_SUBBANKS; s++) begin : g_sb
         logic sb_we;

         assign sb_we = (ic_wr_en[w] & (ic_rw_addr[3] == 1'(s / 2))) |
                        (dbg_wr_way[w] & (ic_debug_addr[3:2] == 2'(s)));

         ic_sram #(
            .DEPTH   (ROW_DEPTH),
            .entry_t (subbank_t)
         ) u_data_ram (
            .clk  (clk),
            .we   (sb_we),
            .re   (way_re[w]),
            .addr (row_idx),
            .d    (sb_wr_data[s]),
            .q    (sb_q[w][s])
         );
      end
   end

   // Hit from the tag side, or the debug way after a debug read
   assign rd_sel = dbg_rd_ff ? dbg_rd_way_ff : ic_rd_hit;

   always_comb begin
      ic_rd_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         for (int s = 0; s < NUM_SUBBANKS; s++) begin
            ic_rd_data[s*SUBBANK_W +: SUBBANK_W] |= {SUBBANK_W{rd_sel[w]}} & sb_q[w][s];
         end
      end
   end

   // Fill and debug share one write data path per subbank
   a_no_fill_dbg_wr : assert property (@(posedge clk) disable iff (!rst_n)
      !((|ic_wr_en) && ic_debug_wr_en))
      else $error("ic_data_array: fill and debug write together");

endmodule

// File: ic_mem.sv
`timescale 1ns/1ps
// Instruction cache memory, four-way tag and data arrays in the parity build
// Reads return one cycle after the strobe, no back-pressure
// ic_tag_valid is sampled in the cycle after the read strobe
// ICACHE_TAG_HIGH sets the cache size and must be within 12..16
module ic_mem
   import ic_pkg::*;
#(
   parameter int ICACHE_TAG_HIGH = 12
) (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic [ADDR_W-1:3]               ic_rw_addr,       // Fetch or fill address
   input  way_vec_t                        ic_wr_en,         // Fill way strobe
   input  logic                            ic_rd_en,         // Fetch read strobe
   input  fill_data_t                      ic_wr_data,       // Two subbanks per beat
   input  logic [ICACHE_TAG_HIGH-1:2]      ic_debug_addr,
   input  logic                            ic_debug_rd_en,
   input  logic                            ic_debug_wr_en,
   input  logic                            ic_debug_tag_array, // High selects tags
   input  way_vec_t                        ic_debug_way,     // One-hot
   input  subbank_t                        ic_debug_wr_data,
   input  way_vec_t                        ic_tag_valid,     // Level per way
   output line_data_t                      ic_rd_data,
   output way_vec_t                        ic_rd_hit,
   output logic                            ic_tag_perr,
   output logic [ADDR_W-ICACHE_TAG_HIGH:0] ictag_debug_rd_data // Parity and tag
);

   ic_tag_array #(
      .ICACHE_TAG_HIGH (ICACHE_TAG_HIGH)
   ) u_tag_array (
      .clk                 (clk),
      .rst_n               (rst_n),
      .ic_rw_addr          (ic_rw_addr),
      .ic_wr_en            (ic_wr_en),
      .ic_rd_en            (ic_rd_en),
      .ic_debug_addr       (ic_debug_addr),
      .ic_debug_rd_en      (ic_debug_rd_en),
      .ic_debug_wr_en      (ic_debug_wr_en),
      .ic_debug_tag_array  (ic_debug_tag_array),
      .ic_debug_way        (ic_debug_way),
      .ic_debug_wr_data    (ic_debug_wr_data),
      .ic_tag_valid        (ic_tag_valid),
      .ic_rd_hit           (ic_rd_hit),
      .ic_tag_perr         (ic_tag_perr),
      .ictag_debug_rd_data (ictag_debug_rd_data)
   );

   ic_data_array #(
      .ICACHE_TAG_HIGH (ICACHE_TAG_HIGH)
   ) u_data_array (
      .clk                (clk),
      .rst_n              (rst_n),
      .ic_rw_addr         (ic_rw_addr[ICACHE_TAG_HIGH-1:3]),   // Row and half only
      .ic_wr_en           (ic_wr_en),
      .ic_rd_en           (ic_rd_en),
      .ic_wr_data         (ic_wr_data),
      .ic_debug_addr      (ic_debug_addr),
      .ic_debug_rd_en     (ic_debug_rd_en),
      .ic_debug_wr_en     (ic_debug_wr_en),
      .ic_debug_tag_array (ic_debug_tag_array),
      .ic_debug_way       (ic_debug_way),
      .ic_debug_wr_data   (ic_debug_wr_data),
      .ic_rd_hit          (ic_rd_hit),                         // Way select for data
      .ic_rd_data         (ic_rd_data)
   );

endmodule

// File: ic_pkg.sv
// Shared geometry and payload types for the instruction cache memory
// Parity build only with 32 data bits and 2 parity bits per subbank
// Subbank parity is produced by the requester and stored as given
package ic_pkg;

   //////////////////////////////////////////////////
   // Geometry
   //////////////////////////////////////////////////

   localparam int NUM_WAYS     = 4;     // Cache ways
   localparam int NUM_SUBBANKS = 4;     // Subbanks per way row
   localparam int SUBBANK_W    = 34;    // 32 data plus 2 parity
   localparam int ADDR_W       = 32;    // Fetch address width

   //////////////////////////////////////////////////
   // Shared types
   //////////////////////////////////////////////////

   // One bit per way for write enables, hits, debug way and valid
   typedef logic [NUM_WAYS-1:0] way_vec_t;

   // One stored data subbank
   typedef logic [SUBBANK_W-1:0] subbank_t;

   // Fill beat with the even subbank in the low half
   typedef logic [2*SUBBANK_W-1:0] fill_data_t;

   // Full row of one way with subbank 0 in the low bits
   typedef logic [NUM_SUBBANKS*SUBBANK_W-1:0] line_data_t;

endpackage

// File: ic_sram.sv
`timescale 1ns/1ps
// Behavioral single-port synchronous RAM
// Registered read output, holds its value when re is low
// Contents and output are unknown until written and read
// A write and a read must not be requested in the same cycle
module ic_sram #(
   parameter int  DEPTH   = 64,
   parameter type entry_t = logic [20:0]
) (
   input  logic                     clk,
   input  logic                     we,
   input  logic                     re,
   input  logic [$clog2(DEPTH)-1:0] addr,
   input  entry_t                   d,
   output entry_t                   q
);

   entry_t mem [DEPTH];

   always_ff @(posedge clk) begin
      if (we) begin
         mem[addr] <= d;             // Write at the edge
      end
      if (re) begin
         q <= mem[addr];             // Read data valid next cycle
      end
   end

   // One port, so a write and a read would collide on the shared address
   a_no_rw_collision : assert property (@(posedge clk) !(we && re))
      else $error("ic_sram: write and read in the same cycle");

endmodule

// File: ic_tag_array.sv
`timescale 1ns/1ps
// Four tag ways with one even parity bit per entry, one entry per 64 byte line
// ICACHE_TAG_HIGH in 12..16, tag is address bits 31 down to ICACHE_TAG_HIGH
// Valid bits are held outside and sampled in the cycle after the read
// Any debug strobe takes the array index from the debug address
module ic_tag_array
   import ic_pkg::*;
#(
   parameter int ICACHE_TAG_HIGH = 12
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [ADDR_W-1:3]                   ic_rw_addr,
   input  way_vec_t                            ic_wr_en,
   input  logic                                ic_rd_en,
   input  logic [ICACHE_TAG_HIGH-1:2]          ic_debug_addr,
   input  logic                                ic_debug_rd_en,
   input  logic                                ic_debug_wr_en,
   input  logic                                ic_debug_tag_array,
   input  way_vec_t                            ic_debug_way,
   input  subbank_t                            ic_debug_wr_data,
   input  way_vec_t                            ic_tag_valid,
   output way_vec_t                            ic_rd_hit,
   output logic                                ic_tag_perr,
   output logic [ADDR_W-ICACHE_TAG_HIGH:0]     ictag_debug_rd_data
);

   localparam int TAG_W     = ADDR_W - ICACHE_TAG_HIGH;
   localparam int TAG_DEPTH = 2 ** (ICACHE_TAG_HIGH - 6);

   typedef logic [TAG_W:0] tag_entry_t;       // Parity in the top bit

   way_vec_t                   tag_fill_we;
   way_vec_t                   dbg_rd_way;
   way_vec_t                   dbg_wr_way;
   way_vec_t                   dbg_rd_way_ff;
   way_vec_t                   way_we;
   way_vec_t                   way_re;
   way_vec_t                   way_perr;
   logic [ICACHE_TAG_HIGH-1:6] tag_idx;
   logic [TAG_W-1:0]           rw_tag_ff;
   tag_entry_t                 tag_wr_data;
   tag_entry_t                 tag_q [NUM_WAYS];

   //////////////////////////////////////////////////
   // Enables and write data
   //////////////////////////////////////////////////

   // Tag goes in with the last beat of a line fill
   assign tag_fill_we = ic_wr_en & {NUM_WAYS{ic_rw_addr[5:3] == 3'b111}};

   assign dbg_rd_way = {NUM_WAYS{ic_debug_rd_en & ic_debug_tag_array}} & ic_debug_way;
   assign dbg_wr_way = {NUM_WAYS{ic_debug_wr_en & ic_debug_tag_array}} & ic_debug_way;

   assign way_we = tag_fill_we | dbg_wr_way;
   assign way_re = {NUM_WAYS{ic_rd_en}} | dbg_rd_way;

   assign tag_idx = (ic_debug_rd_en | ic_debug_wr_en) ? ic_debug_addr[ICACHE_TAG_HIGH-1:6]
                                                      : ic_rw_addr[ICACHE_TAG_HIGH-1:6];

   // Debug writes store tag and parity exactly as supplied
   assign tag_wr_data = (ic_debug_wr_en & ic_debug_tag_array)
      ? {ic_debug_wr_data[ADDR_W], ic_debug_wr_data[ADDR_W-1:ICACHE_TAG_HIGH]}
      : {^ic_rw_addr[ADDR_W-1:ICACHE_TAG_HIGH], ic_rw_addr[ADDR_W-1:ICACHE_TAG_HIGH]};

   always_ff @(posedge clk) begin
      rw_tag_ff <= ic_rw_addr[ADDR_W-1:ICACHE_TAG_HIGH];   // Lines up with RAM output
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         dbg_rd_way_ff <= '0;
      end else begin
         dbg_rd_way_ff <= dbg_rd_way;                        // Debug readback way
      end
   end

   //////////////////////////////////////////////////
   // Tag ways, compare and parity check
   //////////////////////////////////////////////////

   for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
      ic_sram #(
         .DEPTH   (TAG_DEPTH),
         .entry_t (tag_entry_t)
      ) u_tag_ram (
         .clk  (clk),
         .we   (way_we[w]),
         .re   (way_re[w]),
         .addr (tag_idx),
         .d    (tag_wr_data),
         .q    (tag_q[w])
      );

      assign way_perr[w]  = ^tag_q[w];                       // Even parity, odd count is bad
      assign ic_rd_hit[w] = (tag_q[w][TAG_W-1:0] == rw_tag_ff) & ic_tag_valid[w];
   end

   assign ic_tag_perr = |(way_perr & ic_tag_valid);          // Invalid ways are ignored

   always_comb begin
      ictag_debug_rd_data = '0;
      for (int w = 0; w < NUM_WAYS; w++) begin
         ictag_debug_rd_data |= {(TAG_W + 1){dbg_rd_way_ff[w]}} & tag_q[w];
      end
   end

   // A multi-hot debug way would merge several entries on readback
   a_dbg_way_onehot : assert property (@(posedge clk) disable iff (!rst_n)
      (ic_debug_tag_array && (ic_debug_rd_en || ic_debug_wr_en)) |-> $onehot(ic_debug_way))
      else $error("ic_tag_array: debug way not one-hot");

endmodule

// File: ic_mem_model.svh
// Reference contents of the cache memory for inclusion in the testbench module
// Expects ic_pkg to be imported by the including module
// Geometry is fixed at ICACHE_TAG_HIGH of 12
// mdl_valid mirrors the ic_tag_valid levels driven by the testbench
`ifndef IC_MEM_MODEL_SVH
`define IC_MEM_MODEL_SVH

localparam int MDL_TAG_HIGH  = 12;
localparam int MDL_TAG_W     = ADDR_W - MDL_TAG_HIGH;
localparam int MDL_TAG_DEPTH = 2 ** (MDL_TAG_HIGH - 6);
localparam int MDL_ROW_DEPTH = 2 ** (MDL_TAG_HIGH - 4);

logic [MDL_TAG_W:0] mdl_tag  [NUM_WAYS][MDL_TAG_DEPTH];      // Parity in the top bit
subbank_t           mdl_data [NUM_WAYS][MDL_ROW_DEPTH][NUM_SUBBANKS];
way_vec_t           mdl_valid;

// One fill beat that writes the tag only when bits 5:3 are all ones
function automatic void apply_fill(way_vec_t ways, logic [ADDR_W-1:3] addr, fill_data_t d);
   int base;
   base = addr[3] ? 2 : 0;
   for (int w = 0; w < NUM_WAYS; w++) begin
      if (ways[w]) begin
         mdl_data[w][addr[MDL_TAG_HIGH-1:4]][base]     = d[SUBBANK_W-1:0];
         mdl_data[w][addr[MDL_TAG_HIGH-1:4]][base + 1] = d[2*SUBBANK_W-1:SUBBANK_W];
         if (addr[5:3] == 3'b111) begin
            mdl_tag[w][addr[MDL_TAG_HIGH-1:6]] =
               {^addr[ADDR_W-1:MDL_TAG_HIGH], addr[ADDR_W-1:MDL_TAG_HIGH]};
         end
      end
   end
endfunction

function automatic void store_tag_word(way_vec_t way, logic [MDL_TAG_HIGH-1:2] addr,
                                       subbank_t d);
   for (int w = 0; w < NUM_WAYS; w++) begin
      if (way[w]) begin
         mdl_tag[w][addr[MDL_TAG_HIGH-1:6]] = {d[ADDR_W], d[ADDR_W-1:MDL_TAG_HIGH]};
      end
   end
endfunction

function automatic void patch_subbank(way_vec_t way, logic [MDL_TAG_HIGH-1:2] addr,
                                      subbank_t d);
   for (int w = 0; w < NUM_WAYS; w++) begin
      if (way[w]) begin
         mdl_data[w][addr[MDL_TAG_HIGH-1:4]][addr[3:2]] = d;
      end
   end
endfunction

function automatic way_vec_t hit_ways(logic [ADDR_W-1:3] addr);
   way_vec_t hit;
   hit = '0;
   for (int w = 0; w < NUM_WAYS; w++) begin
      hit[w] = mdl_valid[w] &&
               (mdl_tag[w][addr[MDL_TAG_HIGH-1:6]][MDL_TAG_W-1:0] == addr[ADDR_W-1:MDL_TAG_HIGH]);
   end
   return hit;
endfunction

function automatic logic tag_parity_error(logic [ADDR_W-1:3] addr);
   logic perr;
   perr = 1'b0;
   for (int w = 0; w < NUM_WAYS; w++) begin
      perr |= mdl_valid[w] & (^mdl_tag[w][addr[MDL_TAG_HIGH-1:6]]);
   end
   return perr;
endfunction

// OR of the rows of the selected ways
function automatic line_data_t merged_row(way_vec_t ways, logic [MDL_TAG_HIGH-1:4] row);
   line_data_t data;
   data = '0;
   for (int w = 0; w < NUM_WAYS; w++) begin
      for (int s = 0; s < NUM_SUBBANKS; s++) begin
         if (ways[w]) begin
            data[s*SUBBANK_W +: SUBBANK_W] |= mdl_data[w][row][s];
         end
      end
   end
   return data;
endfunction

function automatic logic [MDL_TAG_W:0] tag_readback(way_vec_t way,
                                                    logic [MDL_TAG_HIGH-1:6] idx);
   logic [MDL_TAG_W:0] entry;
   entry = '0;
   for (int w = 0; w < NUM_WAYS; w++) begin
      if (way[w]) begin
         entry |= mdl_tag[w][idx];
      end
   end
   return entry;
endfunction

`endif

// File: tb_ic_mem.sv
`timescale 1ns/1ps
// Testbench for ic_mem at ICACHE_TAG_HIGH of 12 with seeded random stimulus
// Inputs change on the falling edge and each read is checked one falling edge later
// Every tag and data entry is written first so that all reads return known contents
module tb_ic_mem
   import ic_pkg::*;
();
`include "ic_mem_model.svh"

   typedef enum {CHK_NONE, CHK_FETCH, CHK_DBG_DATA, CHK_DBG_TAG} chk_kind_e;

   localparam int N_FILLS     = 24;
   localparam int N_MISS      = 16;
   localparam int N_DBG       = 12;
   localparam int STIM_CYCLES = 4 + 2 * MDL_ROW_DEPTH + NUM_WAYS * MDL_TAG_DEPTH
                                + 12 * N_FILLS + N_MISS + 4 + 17 + 8 + 3 * N_DBG + 1;
   localparam int CYCLE_LIMIT = 2 * STIM_CYCLES + 100;

   logic                    clk;
   logic                    rst_n;
   logic [ADDR_W-1:3]       ic_rw_addr;
   way_vec_t                ic_wr_en;
   logic                    ic_rd_en;
   fill_data_t              ic_wr_data;
   logic [MDL_TAG_HIGH-1:2] ic_debug_addr;
   logic                    ic_debug_rd_en;
   logic                    ic_debug_wr_en;
   logic                    ic_debug_tag_array;
   way_vec_t                ic_debug_way;
   subbank_t                ic_debug_wr_data;
   way_vec_t                ic_tag_valid;
   line_data_t              ic_rd_data;
   way_vec_t                ic_rd_hit;
   logic                    ic_tag_perr;
   logic [MDL_TAG_W:0]      ictag_debug_rd_data;

   int                      seed      = 32'h72fc_01d5;
   int                      errors    = 0;
   int                      checks    = 0;
   int                      cycles    = 0;
   chk_kind_e               pend_kind = CHK_NONE;   // Read issued last cycle
   logic [ADDR_W-1:3]       pend_addr;
   way_vec_t                pend_way;
   logic [MDL_TAG_HIGH-1:2] pend_dbg_addr;
   logic [ADDR_W-1:3]       line_q [$];             // Lines filled so far

   ic_mem #(.ICACHE_TAG_HIGH(MDL_TAG_HIGH)) uut (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > CYCLE_LIMIT) begin
         $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Checks: %0d, errors: %0d", checks, errors);
         $display(">>> FAIL");
         $finish;
      end
   end

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   function automatic way_vec_t rand_way();
      logic [31:0] r;
      r = next_rand();
      return way_vec_t'(1) << r[1:0];                 // One-hot
   endfunction

   // Debug tag word where bad_par flips the stored parity
   function automatic subbank_t tag_word(logic [MDL_TAG_W-1:0] tag, logic bad_par);
      return {1'b0, (^tag) ^ bad_par, tag, {MDL_TAG_HIGH{1'b0}}};
   endfunction

   task automatic report_mismatch(string msg);
      errors++;
      $display("Mismatch at %0t: %s", $time, msg);
   endtask

   task automatic check_pending();
      way_vec_t           exp_hit;
      line_data_t         exp_data;
      logic               exp_perr;
      logic [MDL_TAG_W:0] exp_tag;
      case (pend_kind)
         CHK_FETCH: begin
            exp_hit  = hit_ways(pend_addr);
            exp_data = merged_row(exp_hit, pend_addr[MDL_TAG_HIGH-1:4]);
            exp_perr = tag_parity_error(pend_addr);
            checks  += 3;
            assert (ic_rd_hit === exp_hit) else report_mismatch($sformatf(
               "addr %h hit %b, expected %b", {pend_addr, 3'b000}, ic_rd_hit, exp_hit));
            assert (ic_rd_data === exp_data) else report_mismatch($sformatf(
               "addr %h data %h, expected %h", {pend_addr, 3'b000}, ic_rd_data, exp_data));
            assert (ic_tag_perr === exp_perr) else report_mismatch($sformatf(
               "addr %h tag parity error %b, expected %b", {pend_addr, 3'b000},
               ic_tag_perr, exp_perr));
         end
         CHK_DBG_DATA: begin
            exp_data = merged_row(pend_way, pend_dbg_addr[MDL_TAG_HIGH-1:4]);
            checks++;
            assert (ic_rd_data === exp_data) else report_mismatch($sformatf(
               "debug data way %b %h, expected %h", pend_way, ic_rd_data, exp_data));
         end
         CHK_DBG_TAG: begin
            exp_tag = tag_readback(pend_way, pend_dbg_addr[MDL_TAG_HIGH-1:6]);
            checks++;
            assert (ictag_debug_rd_data === exp_tag) else report_mismatch($sformatf(
               "debug tag way %b %h, expected %h", pend_way, ictag_debug_rd_data, exp_tag));
         end
         default: begin
         end
      endcase
      pend_kind = CHK_NONE;
   endtask

   // Check the read of the last cycle and drop all strobes
   task automatic next_cycle();
      @(negedge clk);
      check_pending();
      ic_wr_en       = '0;
      ic_rd_en       = 1'b0;
      ic_debug_rd_en = 1'b0;
      ic_debug_wr_en = 1'b0;
   endtask

   task automatic fill_beat(way_vec_t ways, logic [ADDR_W-1:3] addr, fill_data_t d);
      next_cycle();
      ic_wr_en   = ways;
      ic_rw_addr = addr;
      ic_wr_data = d;
      apply_fill(ways, addr, d);
   endtask

   // Beats walk bits 5:3 from 000 up to last_beat and only the 111 beat writes the tag
   task automatic fill_line(way_vec_t way, logic [ADDR_W-1:3] line, int last_beat);
      logic [31:0] r0;
      logic [31:0] r1;
      logic [31:0] r2;
      for (int b = 0; b <= last_beat; b++) begin
         r0 = next_rand();
         r1 = next_rand();
         r2 = next_rand();
         fill_beat(way, {line[ADDR_W-1:6], 3'(b)}, {r2[1:0], r1, r2[3:2], r0});
      end
   endtask

   task automatic fetch(logic [ADDR_W-1:3] addr);
      next_cycle();
      ic_rd_en   = 1'b1;
      ic_rw_addr = addr;
      pend_kind  = CHK_FETCH;
      pend_addr  = addr;
   endtask

   task automatic set_valid(way_vec_t ways, logic v);
      next_cycle();
      for (int k = 0; k < NUM_WAYS; k++) begin
         if (ways[k]) begin
            ic_tag_valid[k] = v;
         end
      end
      mdl_valid = ic_tag_valid;
   endtask

   task automatic dbg_write(logic tag_sel, way_vec_t way, logic [MDL_TAG_HIGH-1:2] addr,
                            subbank_t d);
      next_cycle();
      ic_debug_wr_en     = 1'b1;
      ic_debug_tag_array = tag_sel;
      ic_debug_way       = way;
      ic_debug_addr      = addr;
      ic_debug_wr_data   = d;
      if (tag_sel) begin
         store_tag_word(way, addr, d);
      end else begin
         patch_subbank(way, addr, d);
      end
   endtask

   task automatic dbg_read(logic tag_sel, way_vec_t way, logic [MDL_TAG_HIGH-1:2] addr);
      next_cycle();
      ic_debug_rd_en     = 1'b1;
      ic_debug_tag_array = tag_sel;
      ic_debug_way       = way;
      ic_debug_addr      = addr;
      pend_kind          = tag_sel ? CHK_DBG_TAG : CHK_DBG_DATA;
      pend_way           = way;
      pend_dbg_addr      = addr;
   endtask

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      logic [31:0]             r;
      logic [ADDR_W-1:3]       a;
      logic [ADDR_W-1:3]       b;
      way_vec_t                w;
      logic [MDL_TAG_HIGH-1:2] da;
      subbank_t                d;
      rst_n              = 1'b0;
      ic_rw_addr         = '0;
      ic_wr_en           = '0;
      ic_rd_en           = 1'b0;
      ic_wr_data         = '0;
      ic_debug_addr      = '0;
      ic_debug_rd_en     = 1'b0;
      ic_debug_wr_en     = 1'b0;
      ic_debug_tag_array = 1'b0;
      ic_debug_way       = '0;
      ic_debug_wr_data   = '0;
      ic_tag_valid       = '0;
      mdl_valid          = '0;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // All rows in all ways with a pattern taken from the whole address
      for (int i = 0; i < 2 * MDL_ROW_DEPTH; i++) begin
         a = (ADDR_W-3)'(i);
         fill_beat('1, a, {a[4:3], {a, 3'b000} ^ 32'h5A5A_0000, a[5:4], ~{a, 3'b000}});
      end
      for (int i = 0; i < MDL_TAG_DEPTH; i++) begin
         for (int k = 0; k < NUM_WAYS; k++) begin
            da = {(MDL_TAG_HIGH-6)'(i), 4'b0000};
            dbg_write(1'b1, way_vec_t'(1 << k), da,
                      tag_word(MDL_TAG_W'(32'hF0000 + 64 * k + i), 1'b0));   // Distinct per way
         end
      end

      // Full line fills with two pipelined fetches after each
      for (int i = 0; i < N_FILLS; i++) begin
         w = rand_way();
         r = next_rand();
         a = r[ADDR_W-1:3];
         fill_line(w, a, 7);
         set_valid(w, 1'b1);
         line_q.push_back(a);
         r = next_rand();
         fetch({a[ADDR_W-1:6], r[2:0]});
         fetch({a[ADDR_W-1:6], r[5:3]});
      end
      foreach (line_q[i]) begin
         fetch(line_q[i]);
      end

      // Misses and a matching tag in a way held invalid
      repeat (N_MISS) begin
         r = next_rand();
         fetch(r[ADDR_W-1:3]);
      end
      a = line_q[$];                                  // w still holds its way
      set_valid(w, 1'b0);
      fetch(a);
      fetch({a[ADDR_W-1:6], 3'b101});
      set_valid(w, 1'b1);

      // Fill stopped before the 111 beat leaves the old tag
      b = a;
      b[ADDR_W-1:MDL_TAG_HIGH] = ~a[ADDR_W-1:MDL_TAG_HIGH];
      fill_line(w, b, 6);
      fetch(a);
      fetch(b);
      for (int k = 0; k < 8; k++) begin
         fetch({a[ADDR_W-1:6], 3'(k)});
      end

      // Bad tag parity is seen only while the way is valid
      da = {a[MDL_TAG_HIGH-1:6], 4'b0000};
      dbg_write(1'b1, w, da, tag_word(a[ADDR_W-1:MDL_TAG_HIGH], 1'b1));
      fetch(a);
      dbg_read(1'b1, w, da);
      set_valid(w, 1'b0);
      fetch(a);
      set_valid(w, 1'b1);
      dbg_write(1'b1, w, da, tag_word(a[ADDR_W-1:MDL_TAG_HIGH], 1'b0));
      fetch(a);

      // Debug subbank writes with data and tag readback
      repeat (N_DBG) begin
         w  = rand_way();
         r  = next_rand();
         da = r[MDL_TAG_HIGH-1:2];
         d  = {r[31:30], next_rand()};
         dbg_write(1'b0, w, da, d);
         dbg_read(1'b0, w, da);
         dbg_read(1'b1, w, da);
      end

      next_cycle();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule
